// ==== Bender.yml ====
package:
  name: mini_core

sources:
  - core_pkg.sv
  - fetch_unit.sv
  - prefetch_queue.sv
  - instr_decoder.sv
  - reg_file.sv
  - exec_stage.sv
  - mini_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mini_core.sv

// ==== core_pkg.sv ====
//////////////////////////////
// Core package
// Widths, opcodes, the instruction word union and the port
// structs shared by the blocks of the mini RV32I core
//////////////////////////////

package core_pkg;

  parameter int unsigned XLEN       = 32;
  parameter int unsigned REG_ADDR_W = 5;

  // Major opcodes that are executed
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  // Writeback and control class of a decoded instruction
  typedef enum logic [2:0] {
    KIND_ALU,
    KIND_LUI,
    KIND_JAL,
    KIND_BEQ,
    KIND_BNE
  } kind_e;

  //////////////////////////////
  // Instruction word views
  //////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_view_t;

  // Upper twenty bits also carry the U and J immediates
  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } instr_u;

  //////////////////////////////
  // Port structs
  //////////////////////////////

  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_u          insn;
  } fetch_item_t;

  // Wishbone classic master outputs
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
    logic                  illegal;
  } retire_t;

endpackage

// ==== exec_stage.sv ====
//////////////////////////////
// Execute stage
// Retires the queue head each cycle it is valid with ALU,
// branch decision, register write and the retire report
//////////////////////////////

`timescale 1ns/1ns

module exec_stage import core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  fetch_item_t           item_i,
  input  alu_op_e               alu_op_i,
  input  logic                  use_imm_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  kind_e                 kind_i,
  input  logic                  illegal_i,
  input  logic [XLEN-1:0]       rdata_a_i,
  input  logic [XLEN-1:0]       rdata_b_i,
  output logic                  pop_o,
  output redirect_t             redirect_o,
  output logic                  we_o,
  output logic [REG_ADDR_W-1:0] waddr_o,
  output logic [XLEN-1:0]       wdata_o,
  output logic                  retire_valid_o,
  output retire_t               retire_o
);

  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] link_pc;
  logic [XLEN-1:0] wdata;
  logic            rs_equal;
  logic            taken;
  logic            writes;

  // Head leaves in every valid cycle
  assign pop_o = valid_i;

  //////////////////////////////
  // ALU
  //////////////////////////////

  assign op_b = use_imm_i ? imm_i : rdata_b_i;

  always_comb begin
    case (alu_op_i)
      ALU_SUB: alu_res = rdata_a_i - op_b;
      ALU_AND: alu_res = rdata_a_i & op_b;
      ALU_OR:  alu_res = rdata_a_i | op_b;
      ALU_XOR: alu_res = rdata_a_i ^ op_b;
      ALU_SLT: alu_res = XLEN'($signed(rdata_a_i) < $signed(op_b));
      ALU_SLL: alu_res = rdata_a_i << op_b[4:0];
      ALU_SRL: alu_res = rdata_a_i >> op_b[4:0];
      default: alu_res = rdata_a_i + op_b;
    endcase
  end

  assign link_pc  = item_i.pc + XLEN'(4);
  assign rs_equal = (rdata_a_i == rdata_b_i);

  // Result select and control flow
  always_comb begin
    wdata  = alu_res;
    writes = 1'b1;
    taken  = 1'b0;
    case (kind_i)
      KIND_LUI: wdata = imm_i;
      KIND_JAL: begin
        wdata = link_pc;
        taken = 1'b1;
      end
      KIND_BEQ: begin
        wdata  = '0;
        writes = 1'b0;
        taken  = rs_equal;
      end
      KIND_BNE: begin
        wdata  = '0;
        writes = 1'b0;
        taken  = !rs_equal;
      end
      default: ;
    endcase
    // Illegal words leave no trace but the retire record
    if (illegal_i) begin
      wdata  = '0;
      writes = 1'b0;
      taken  = 1'b0;
    end
  end

  assign redirect_o.valid  = valid_i && taken;
  assign redirect_o.target = item_i.pc + imm_i;

  assign we_o    = valid_i && writes;
  assign waddr_o = rd_i;
  assign wdata_o = wdata;

  //////////////////////////////
  // Retire report
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      retire_o.pc      <= item_i.pc;
      retire_o.insn    <= item_i.insn;
      retire_o.rd      <= writes ? rd_i : '0;
      retire_o.wdata   <= wdata;
      retire_o.illegal <= illegal_i;
    end
  end

endmodule

// ==== fetch_unit.sv ====
//////////////////////////////
// Fetch unit
// Wishbone classic master that reads instruction words at the
// fetch pc and pushes them into the prefetch queue. Taken
// branches and jumps reload the pc.
//////////////////////////////

`timescale 1ns/1ns

module fetch_unit import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  output wb_req_t         wb_req_o,
  input  wb_rsp_t         wb_rsp_i,
  input  logic            full_i,
  input  redirect_t       redirect_i,
  output logic            push_o,
  output fetch_item_t     item_o
);

  typedef enum logic {
    S_IDLE,
    S_WAIT
  } state_e;

  state_e          state_q;
  wb_req_t         req_q;
  logic [XLEN-1:0] pc_q;
  logic            drop_q;
  logic            ack;

  // Only an ack for our own open access counts
  assign ack = (state_q == S_WAIT) && wb_rsp_i.ack;

  //////////////////////////////
  // Bus master
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      req_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // Access waits until a redirect has settled the pc
          if (!full_i && !redirect_i.valid) begin
            state_q   <= S_WAIT;
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.adr <= pc_q;
          end
        end
        default: begin
          if (wb_rsp_i.ack) begin
            state_q   <= S_IDLE;
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Fetch pc and stale words
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q   <= boot_addr_i;
      drop_q <= 1'b0;
    end else begin
      if (redirect_i.valid) begin
        pc_q <= redirect_i.target;
      end else if (push_o) begin
        pc_q <= pc_q + XLEN'(4);
      end
      // Word of an access overtaken by a redirect is thrown away
      if (ack) begin
        drop_q <= 1'b0;
      end else if (redirect_i.valid && state_q == S_WAIT) begin
        drop_q <= 1'b1;
      end
    end
  end

  assign wb_req_o    = req_q;
  assign push_o      = ack && !drop_q;
  assign item_o.pc   = req_q.adr;
  assign item_o.insn = wb_rsp_i.dat;

endmodule

// ==== instr_decoder.sv ====
//////////////////////////////
// Instruction decoder
// Splits the head word into ALU operation, operands and
// immediate, and flags every encoding the core lacks
//////////////////////////////

`timescale 1ns/1ns

module instr_decoder import core_pkg::*; (
  input  instr_u                instr_i,
  output alu_op_e               alu_op_o,
  output logic                  use_imm_o,
  output logic [XLEN-1:0]       imm_o,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output kind_e                 kind_o,
  output logic                  illegal_o
);

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_j_type;

  assign funct3 = instr_i.r_view.funct3;
  assign funct7 = instr_i.r_view.funct7;
  assign rs1_o  = instr_i.r_view.rs1;
  assign rs2_o  = instr_i.r_view.rs2;
  assign rd_o   = instr_i.r_view.rd;

  //////////////////////////////
  // Immediates
  //////////////////////////////

  assign imm_i_type = {{20{instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};
  assign imm_u_type = {instr_i.i_view.imm12, instr_i.i_view.rs1,
                       instr_i.i_view.funct3, 12'b0};
  // B type scatters its bits over funct7 and rd
  assign imm_b_type = {{20{funct7[6]}}, instr_i.r_view.rd[0], funct7[5:0],
                       instr_i.r_view.rd[4:1], 1'b0};
  assign imm_j_type = {{12{instr_i.i_view.imm12[11]}}, instr_i.i_view.rs1,
                       instr_i.i_view.funct3, instr_i.i_view.imm12[0],
                       instr_i.i_view.imm12[10:1], 1'b0};

  always_comb begin
    alu_op_o  = ALU_ADD;
    use_imm_o = 1'b0;
    imm_o     = imm_i_type;
    kind_o    = KIND_ALU;
    illegal_o = 1'b0;
    case (instr_i.r_view.opcode)
      OPC_OP: begin
        if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op_o = ALU_SUB;
        end else if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  alu_op_o = ALU_ADD;
            3'b001:  alu_op_o = ALU_SLL;
            3'b010:  alu_op_o = ALU_SLT;
            3'b100:  alu_op_o = ALU_XOR;
            3'b101:  alu_op_o = ALU_SRL;
            3'b110:  alu_op_o = ALU_OR;
            3'b111:  alu_op_o = ALU_AND;
            default: illegal_o = 1'b1;
          endcase
        end else begin
          illegal_o = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        use_imm_o = 1'b1;
        // No immediate shifts and no SLTIU
        case (funct3)
          3'b000:  alu_op_o = ALU_ADD;
          3'b010:  alu_op_o = ALU_SLT;
          3'b100:  alu_op_o = ALU_XOR;
          3'b110:  alu_op_o = ALU_OR;
          3'b111:  alu_op_o = ALU_AND;
          default: illegal_o = 1'b1;
        endcase
      end
      OPC_LUI: begin
        kind_o = KIND_LUI;
        imm_o  = imm_u_type;
      end
      OPC_JAL: begin
        kind_o = KIND_JAL;
        imm_o  = imm_j_type;
      end
      OPC_BRANCH: begin
        imm_o = imm_b_type;
        case (funct3)
          3'b000:  kind_o = KIND_BEQ;
          3'b001:  kind_o = KIND_BNE;
          default: illegal_o = 1'b1;
        endcase
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

// ==== mini_core.sv ====
//////////////////////////////
// Mini RV32I core
// Fetch over Wishbone, prefetch queue, decode and single
// cycle execute with a retire report per instruction
//////////////////////////////

`timescale 1ns/1ns

module mini_core import core_pkg::*; #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic [XLEN-1:0] boot_addr_i,
  output wb_req_t         wb_req_o,
  input  wb_rsp_t         wb_rsp_i,
  output logic            retire_valid_o,
  output retire_t         retire_o
);

  // Fetch to queue
  logic                  push;
  logic                  full;
  fetch_item_t           fetch_item;

  // Queue to execute
  logic                  head_valid;
  logic                  pop;
  fetch_item_t           head_item;
  redirect_t             redirect;

  // Decoded head
  alu_op_e               alu_op;
  logic                  use_imm;
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  kind_e                 kind;
  logic                  illegal;

  // Register file ports
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  fetch_unit u_fetch (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .boot_addr_i (boot_addr_i),
    .wb_req_o    (wb_req_o),
    .wb_rsp_i    (wb_rsp_i),
    .full_i      (full),
    .redirect_i  (redirect),
    .push_o      (push),
    .item_o      (fetch_item)
  );

  prefetch_queue #(
    .FifoDepth (FifoDepth)
  ) u_queue (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .item_i  (fetch_item),
    .full_o  (full),
    .pop_i   (pop),
    .flush_i (redirect.valid),
    .valid_o (head_valid),
    .item_o  (head_item)
  );

  instr_decoder u_decoder (
    .instr_i   (head_item.insn),
    .alu_op_o  (alu_op),
    .use_imm_o (use_imm),
    .imm_o     (imm),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rd_o      (rd),
    .kind_o    (kind),
    .illegal_o (illegal)
  );

  reg_file u_regs (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  exec_stage u_exec (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .valid_i        (head_valid),
    .item_i         (head_item),
    .alu_op_i       (alu_op),
    .use_imm_i      (use_imm),
    .imm_i          (imm),
    .rd_i           (rd),
    .kind_i         (kind),
    .illegal_i      (illegal),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .pop_o          (pop),
    .redirect_o     (redirect),
    .we_o           (rf_we),
    .waddr_o        (rf_waddr),
    .wdata_o        (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

// ==== prefetch_queue.sv ====
//////////////////////////////
// Prefetch queue
// Circular buffer of fetched words with their pc, emptied
// in one cycle when the program flow is redirected
//////////////////////////////

`timescale 1ns/1ns

module prefetch_queue import core_pkg::*; #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic        clk,
  input  logic        rst_ni,
  input  logic        push_i,
  input  fetch_item_t item_i,
  output logic        full_o,
  input  logic        pop_i,
  input  logic        flush_i,
  output logic        valid_o,
  output fetch_item_t item_o
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  fetch_item_t     mem_q [FifoDepth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    ptr_inc = (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign full_o  = (count_q == CntW'(FifoDepth));
  assign valid_o = (count_q != '0);
  assign item_o  = mem_q[rd_ptr_q];

  // Flush wins over a push in the same cycle
  assign do_push = push_i && !full_o && !flush_i;
  assign do_pop  = pop_i && valid_o && !flush_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + CntW'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

endmodule

// ==== reg_file.sv ====
//////////////////////////////
// Register file
// 32 integer registers, two read ports and one write port,
// x0 reads as zero
//////////////////////////////

`timescale 1ns/1ns

module reg_file import core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  localparam int unsigned NumRegs = 2 ** REG_ADDR_W;

  // No storage behind x0
  logic [XLEN-1:0] regs_q [NumRegs-1:1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== tb_checks.svh ====
//////////////////////////////
// Testbench checks
// Instruction encoders for building programs and the compare
// tasks for retire records and retire counts
//////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
endfunction

function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
endfunction

function automatic logic [31:0] enc_lui(int imm20, int rd);
  return {imm20[19:0], rd[4:0], OPC_LUI};
endfunction

// J type scrambles the offset bits
function automatic logic [31:0] enc_jal(int off, int rd);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
endfunction

function automatic logic [31:0] enc_b(int off, int rs2, int rs1, int f3);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
          OPC_BRANCH};
endfunction

task automatic check_retire(input retire_t want, input retire_t got);
  if (got !== want) begin
    retire_errs++;
    $display("error at %0t ns: retire_o expected pc=%h insn=%h rd=%0d wdata=%h ill=%b",
             $time, want.pc, want.insn, want.rd, want.wdata, want.illegal);
    $display("      got pc=%h insn=%h rd=%0d wdata=%h ill=%b",
             got.pc, got.insn, got.rd, got.wdata, got.illegal);
  end
endtask

task automatic check_count(input int want, input int got);
  if (got != want) begin
    count_errs++;
    $display("error at %0t ns: retire_valid_o count expected %0d got %0d",
             $time, want, got);
  end
endtask

`endif

// ==== tb_mini_core.sv ====
//////////////////////////////
// Testbench for the mini core
// Wishbone memory with random ack delay, directed programs
// and a check of every retire record
//////////////////////////////

`timescale 1ns/1ns

module tb_mini_core import core_pkg::*; ();

  localparam logic [31:0] Seed = 32'h13ed_997f;

  logic            clk = 1'b0;
  logic            rst_ni;
  logic [XLEN-1:0] boot_addr = '0;
  wb_req_t         wb_req;
  wb_rsp_t         wb_rsp = '0;
  logic            retire_valid;
  retire_t         retire;

  logic [31:0] mem [256];
  logic [31:0] rng_q = Seed;
  logic [1:0]  wait_q;
  logic [31:0] prog [$];
  retire_t     want_q [$];
  int          retire_errs = 0;
  int          count_errs = 0;
  int          bus_errs = 0;
  int          cycle_cnt = 0;
  int          limit_cycles = 0;

  `include "tb_checks.svh"

  mini_core #(
    .FifoDepth (4)
  ) dut (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr),
    .wb_req_o       (wb_req),
    .wb_rsp_i       (wb_rsp),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  //////////////////////////////
  // Wishbone memory model
  //////////////////////////////

  // Ack after 0 to 3 wait cycles, one word per access
  always @(posedge clk) begin
    if (!rst_ni) begin
      wb_rsp.ack <= 1'b0;
      wait_q     <= '0;
    end else begin
      wb_rsp.ack <= 1'b0;
      if (wb_req.cyc && wb_req.we) begin
        bus_errs++;
        $display("error at %0t ns: wb_req_o.we expected 0 got 1", $time);
      end
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (wait_q == '0) begin
          wb_rsp.ack <= 1'b1;
          wb_rsp.dat <= mem[wb_req.adr[9:2]];
          rng_q      <= xorshift(rng_q);
          wait_q     <= rng_q[1:0];
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > limit_cycles) begin
      $display("timeout: the programs did not finish within %0d cycles", limit_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic add_expected(input int pc, input int rd, input logic [31:0] wdata,
                              input logic ill = 1'b0);
    retire_t rec;
    rec.pc      = pc;
    rec.insn    = prog[pc / 4];
    rec.rd      = rd[4:0];
    rec.wdata   = wdata;
    rec.illegal = ill;
    want_q.push_back(rec);
  endtask

  // Load, reset, then compare records up to the final self loop
  task automatic run_program(input int end_pc);
    int  got;
    logic done;
    got  = 0;
    done = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = i * 32'h9e37_79b9;
    end
    foreach (prog[i]) begin
      mem[i] = prog[i];
    end
    limit_cycles += 160 * prog.size();
    @(posedge clk);
    rst_ni <= 1'b0;
    repeat (5) @(posedge clk);
    rst_ni <= 1'b1;
    while (!done) begin
      @(negedge clk);
      if (retire_valid) begin
        if (got < want_q.size()) begin
          check_retire(want_q[got], retire);
        end
        got++;
        done = (retire.pc == end_pc);
      end
    end
    check_count(want_q.size(), got);
    prog.delete();
    want_q.delete();
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_imm_lui();
    prog = '{enc_i(100, 0, 0, 1), enc_i(-7, 1, 0, 2), enc_i(15, 2, 7, 3),
             enc_i(256, 3, 6, 4), enc_i(-1, 4, 4, 5), enc_i(0, 5, 2, 6),
             enc_lui(20'h12345, 7), enc_i(1, 7, 0, 0), enc_i(5, 0, 0, 8), enc_jal(0, 0)};
    add_expected(0, 1, 32'd100);
    add_expected(4, 2, 32'd100 - 32'd7);
    add_expected(8, 3, 32'd93 & 32'd15);
    add_expected(12, 4, 32'd13 | 32'd256);
    add_expected(16, 5, ~32'h0000_010d);
    add_expected(20, 6, 32'd1);
    add_expected(24, 7, 32'h1234_5000);
    add_expected(28, 0, 32'h1234_5001);
    add_expected(32, 8, 32'd5);
    add_expected(36, 0, 32'd40);
    run_program(36);
  endtask

  task automatic test_reg_reg();
    prog = '{enc_i(-20, 0, 0, 1), enc_i(6, 0, 0, 2), enc_r(0, 2, 1, 0, 3),
             enc_r(32, 2, 3, 0, 4), enc_r(0, 2, 4, 2, 5), enc_r(0, 5, 2, 1, 6),
             enc_r(0, 6, 4, 5, 7), enc_r(0, 6, 7, 4, 8), enc_r(0, 7, 8, 7, 9),
             enc_r(0, 2, 9, 6, 10), enc_jal(0, 0)};
    add_expected(0, 1, 32'hffff_ffec);
    add_expected(4, 2, 32'd6);
    add_expected(8, 3, 32'hffff_fff2);
    add_expected(12, 4, 32'hffff_ffec);
    add_expected(16, 5, 32'd1);
    add_expected(20, 6, 32'd12);
    add_expected(24, 7, 32'h000f_ffff);
    add_expected(28, 8, 32'h000f_fff3);
    add_expected(32, 9, 32'h000f_fff3);
    add_expected(36, 10, 32'h000f_fff7);
    add_expected(40, 0, 32'd44);
    run_program(40);
  endtask

  task automatic test_branch();
    prog = '{enc_i(3, 0, 0, 1), enc_i(3, 0, 0, 2), enc_b(12, 2, 1, 0),
             enc_i(1, 0, 0, 3), enc_i(2, 0, 0, 3), enc_b(8, 2, 1, 1),
             enc_i(7, 3, 0, 4), enc_jal(0, 0)};
    add_expected(0, 1, 32'd3);
    add_expected(4, 2, 32'd3);
    add_expected(8, 0, 32'd0);
    add_expected(20, 0, 32'd0);
    add_expected(24, 4, 32'd7);
    add_expected(28, 0, 32'd32);
    run_program(28);
  endtask

  task automatic test_jal();
    prog = '{enc_jal(8, 1), enc_i(1, 0, 0, 9), enc_i(3, 0, 0, 2), enc_i(-1, 2, 0, 2),
             enc_b(8, 0, 2, 0), enc_jal(-8, 0), enc_i(0, 1, 0, 3), enc_jal(0, 0)};
    add_expected(0, 1, 32'd4);
    add_expected(8, 2, 32'd3);
    // Loop body runs three times, exit on the last pass
    for (int k = 2; k >= 0; k--) begin
      add_expected(12, 2, k);
      add_expected(16, 0, 32'd0);
      if (k != 0) begin
        add_expected(20, 0, 32'd24);
      end
    end
    add_expected(24, 3, 32'd4);
    add_expected(28, 0, 32'd32);
    run_program(28);
  endtask

  task automatic test_illegal();
    prog = '{enc_i(42, 0, 0, 5), 32'h0000_2283, enc_r(32, 5, 5, 5, 5),
             enc_i(1, 5, 0, 6), enc_jal(0, 0)};
    add_expected(0, 5, 32'd42);
    add_expected(4, 0, 32'd0, 1'b1);
    add_expected(8, 0, 32'd0, 1'b1);
    add_expected(12, 6, 32'd43);
    add_expected(16, 0, 32'd20);
    run_program(16);
  endtask

  task automatic test_long_random();
    for (int i = 1; i <= 40; i++) begin
      prog.push_back(enc_i(i, 1, 0, 1));
    end
    prog.push_back(enc_jal(0, 0));
    for (int i = 1; i <= 40; i++) begin
      add_expected((i - 1) * 4, 1, i * (i + 1) / 2);
    end
    add_expected(160, 0, 32'd164);
    run_program(160);
  endtask

  initial begin
    rst_ni = 1'b0;
    test_imm_lui();
    test_reg_reg();
    test_branch();
    test_jal();
    test_illegal();
    test_long_random();
    $display("errors: retire %0d, count %0d, bus %0d", retire_errs, count_errs, bus_errs);
    if (retire_errs + count_errs + bus_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
core_pkg.sv
fetch_unit.sv
prefetch_queue.sv
instr_decoder.sv
reg_file.sv
exec_stage.sv
mini_core.sv
tb_mini_core.sv
